//--- design/controlUnit.sv
//--------------------
// Main and ALU decoders in decode, then the control word carried
// through execute, memory and writeback. A stall bubbles execute.
//--------------------
`timescale 1ns/1ps
`default_nettype none

module controlUnit import mipsPkg::*; (
  input  wire logic                   clk,
  input  wire logic                   reset,
  input  wire logic [OpcodeWidth-1:0] opD,
  input  wire logic [FunctWidth-1:0]  functD,
  input  wire logic                   stall,
  output logic                        branchD,
  output logic                        regWriteE, regWriteM, regWriteW,
  output logic                        memToRegE, memToRegM, memToRegW,
  output logic                        memWriteM,
  output logic                        aluSrcE,
  output logic                        regDstE,
  output aluControlT                  aluControlE
);

  logic       regWriteD, regDstD, aluSrcD, memWriteD, memToRegD, memWriteE;
  aluControlT aluControlD, functControl;

  always_comb begin
    case (functD)
      FnAdd, FnAddu: functControl = AluAdd;
      FnSub, FnSubu: functControl = AluSub;
      FnAnd:         functControl = AluAnd;
      FnOr:          functControl = AluOr;
      FnXor:         functControl = AluXor;
      FnNor:         functControl = AluNor;
      FnSlt:         functControl = AluSlt;
      FnSltu:        functControl = AluSltu;
      default:       functControl = AluAdd;  // Reset bubble lands here
    endcase
  end

  always_comb begin
    regWriteD   = 1'b0;
    regDstD     = 1'b0;
    aluSrcD     = 1'b0;
    memWriteD   = 1'b0;
    memToRegD   = 1'b0;
    branchD     = 1'b0;
    aluControlD = AluAdd;
    case (opD)
      OpRType: begin
        regWriteD   = 1'b1;
        regDstD     = 1'b1;
        aluControlD = functControl;
      end
      OpLw: begin
        regWriteD = 1'b1;
        aluSrcD   = 1'b1;
        memToRegD = 1'b1;
      end
      OpSw: begin
        aluSrcD   = 1'b1;
        memWriteD = 1'b1;
      end
      OpBeq: branchD = 1'b1;  // Compared in decode, ALU unused
      OpAddi, OpAddiu: begin
        regWriteD = 1'b1;
        aluSrcD   = 1'b1;
      end
      OpSlti, OpAndi, OpOri: begin
        regWriteD   = 1'b1;
        aluSrcD     = 1'b1;
        aluControlD = (opD == OpSlti) ? AluSlt : ((opD == OpAndi) ? AluAnd : AluOr);
      end
      default: ;  // Unknown opcode acts as a no-op
    endcase
  end

  // Pipeline registers --------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      regWriteE   <= 1'b0;
      memToRegE   <= 1'b0;
      memWriteE   <= 1'b0;
      aluSrcE     <= 1'b0;
      regDstE     <= 1'b0;
      aluControlE <= AluAnd;
    end else if (stall) begin
      regWriteE   <= 1'b0;  // Bubble behind a held decode
      memToRegE   <= 1'b0;
      memWriteE   <= 1'b0;
      aluSrcE     <= 1'b0;
      regDstE     <= 1'b0;
      aluControlE <= AluAnd;
    end else begin
      regWriteE   <= regWriteD;
      memToRegE   <= memToRegD;
      memWriteE   <= memWriteD;
      aluSrcE     <= aluSrcD;
      regDstE     <= regDstD;
      aluControlE <= aluControlD;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      regWriteM <= 1'b0;
      memToRegM <= 1'b0;
      memWriteM <= 1'b0;
      regWriteW <= 1'b0;
      memToRegW <= 1'b0;
    end else begin
      regWriteM <= regWriteE;
      memToRegM <= memToRegE;
      memWriteM <= memWriteE;
      regWriteW <= regWriteM;
      memToRegW <= memToRegM;
    end
  end

  // A store never writes back, even after two stages of pipelining
  assert property (@(posedge clk) disable iff (reset) !(memWriteM && regWriteM));

endmodule

`default_nettype wire

//--- design/executeWriteback.sv
//--------------------
// Execute-stage registers and ALU, then the memory and writeback
// registers and the result select feeding the register file.
//--------------------
`timescale 1ns/1ps
`default_nettype none

module executeWriteback import mipsPkg::*; (
  input  wire logic                    clk,
  input  wire logic                    reset,
  input  wire logic                    stall,
  input  wire logic [DataWidth-1:0]    srcAD, srcBD, immD,
  input  wire logic [RegAddrWidth-1:0] rsD, rtD, rdD,
  input  wire logic [1:0]              forwardAE, forwardBE,
  input  wire logic                    aluSrcE,
  input  wire logic                    regDstE,
  input  aluControlT                   aluControlE,
  input  wire logic                    memToRegW,
  input  wire logic [DataWidth-1:0]    readDataM,
  output logic [RegAddrWidth-1:0]      rsE, rtE,
  output logic [RegAddrWidth-1:0]      writeRegE, writeRegM, writeRegW,
  output logic [DataWidth-1:0]         aluOutM, writeDataM, resultW
);

  logic [DataWidth-1:0]    srcAE, srcBE, immE, opA, fwdBE, opB, aluOutE;
  logic [DataWidth-1:0]    diff, aluOutW, readDataW;
  logic [RegAddrWidth-1:0] rdE;
  logic                    sltSigned, sltUnsigned;

  // Execute --------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      {srcAE, srcBE, immE} <= '0;
      {rsE, rtE, rdE}      <= '0;
    end else if (stall) begin
      {srcAE, srcBE, immE} <= '0;  // Bubble behind a held decode
      {rsE, rtE, rdE}      <= '0;
    end else begin
      {srcAE, srcBE, immE} <= {srcAD, srcBD, immD};
      {rsE, rtE, rdE}      <= {rsD, rtD, rdD};
    end
  end

  always_comb begin
    case (forwardAE)
      2'b10:   opA = aluOutM;
      2'b01:   opA = resultW;
      default: opA = srcAE;
    endcase
    case (forwardBE)
      2'b10:   fwdBE = aluOutM;
      2'b01:   fwdBE = resultW;
      default: fwdBE = srcBE;
    endcase
  end

  assign opB       = aluSrcE ? immE : fwdBE;
  assign writeRegE = regDstE ? rdE : rtE;

  // ALU, signed compare corrects the difference sign on overflow
  assign diff        = opA - opB;
  assign sltSigned   = (opA[DataWidth-1] != opB[DataWidth-1]) ? opA[DataWidth-1]
                                                              : diff[DataWidth-1];
  assign sltUnsigned = opA < opB;

  always_comb begin
    case (aluControlE)
      AluAnd:  aluOutE = opA & opB;
      AluOr:   aluOutE = opA | opB;
      AluAdd:  aluOutE = opA + opB;
      AluSub:  aluOutE = diff;
      AluSlt:  aluOutE = {{(DataWidth-1){1'b0}}, sltSigned};
      AluSltu: aluOutE = {{(DataWidth-1){1'b0}}, sltUnsigned};
      AluXor:  aluOutE = opA ^ opB;
      AluNor:  aluOutE = ~(opA | opB);
      default: aluOutE = '0;
    endcase
  end

  // Memory and writeback --------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      {aluOutM, writeDataM, writeRegM} <= '0;
      {aluOutW, readDataW, writeRegW}  <= '0;
    end else begin
      {aluOutM, writeDataM, writeRegM} <= {aluOutE, fwdBE, writeRegE};
      {aluOutW, readDataW, writeRegW}  <= {aluOutM, readDataM, writeRegM};
    end
  end

  assign resultW = memToRegW ? readDataW : aluOutW;

endmodule

`default_nettype wire

//--- design/fetchDecode.sv
//--------------------
// PC, fetch-to-decode register and the decode-stage datapath: field
// split, immediate extension, branch compare and next-PC choice.
//--------------------
`timescale 1ns/1ps
`default_nettype none

module fetchDecode import mipsPkg::*; (
  input  wire logic                    clk,
  input  wire logic                    reset,
  input  wire logic [DataWidth-1:0]    instrF,
  input  wire logic                    stall,
  input  wire logic                    branchD,
  input  wire logic                    forwardAD,
  input  wire logic                    forwardBD,
  input  wire logic [DataWidth-1:0]    readA,
  input  wire logic [DataWidth-1:0]    readB,
  input  wire logic [DataWidth-1:0]    aluOutM,
  output logic [DataWidth-1:0]         pcF,
  output logic [OpcodeWidth-1:0]       opD,
  output logic [FunctWidth-1:0]        functD,
  output logic [RegAddrWidth-1:0]      rsD, rtD, rdD,
  output logic [DataWidth-1:0]         srcAD,
  output logic [DataWidth-1:0]         srcBD,
  output logic [DataWidth-1:0]         immD
);

  logic [DataWidth-1:0] pcPlus4F, pcPlus4D, instrD, pcBranchD, pcNextF;
  logic [ImmWidth-1:0]  imm;
  logic                 zeroExt, pcSrcD;

  // Fetch --------------------
  assign pcPlus4F = pcF + DataWidth'(4);
  assign pcNextF  = pcSrcD ? pcBranchD : pcPlus4F;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pcF      <= ResetPc;
      instrD   <= '0;  // Clears to a harmless R-type bubble
      pcPlus4D <= '0;
    end else if (!stall) begin
      pcF      <= pcNextF;
      instrD   <= instrF;
      pcPlus4D <= pcPlus4F;
    end
  end

  // Decode --------------------
  assign opD    = instrD[DataWidth-1 -: OpcodeWidth];
  assign rsD    = instrD[25:21];
  assign rtD    = instrD[20:16];
  assign rdD    = instrD[15:11];
  assign functD = instrD[FunctWidth-1:0];
  assign imm    = instrD[ImmWidth-1:0];

  // Logical immediates zero-extend
  assign zeroExt = (opD == OpAndi) || (opD == OpOri);
  assign immD    = zeroExt ? {{(DataWidth-ImmWidth){1'b0}}, imm}
                           : {{(DataWidth-ImmWidth){imm[ImmWidth-1]}}, imm};

  assign srcAD = forwardAD ? aluOutM : readA;
  assign srcBD = forwardBD ? aluOutM : readB;

  // Target is relative to the delay slot
  assign pcBranchD = pcPlus4D + {immD[DataWidth-3:0], 2'b00};
  assign pcSrcD    = branchD && (srcAD == srcBD);

endmodule

`default_nettype wire

//--- design/hazardUnit.sv
//--------------------
// Forwarding selects for decode and execute, and the stall that holds
// fetch and decode while execute takes a bubble.
//--------------------
`timescale 1ns/1ps
`default_nettype none

module hazardUnit import mipsPkg::*; (
  input  wire logic [RegAddrWidth-1:0] rsD, rtD, rsE, rtE,
  input  wire logic [RegAddrWidth-1:0] writeRegE, writeRegM, writeRegW,
  input  wire logic                    regWriteE, regWriteM, regWriteW,
  input  wire logic                    memToRegE, memToRegM,
  input  wire logic                    branchD,
  output logic                         forwardAD, forwardBD,
  output logic [1:0]                   forwardAE, forwardBE,
  output logic                         stall
);

  logic loadUseStall, branchStall;

  // Comparator sources, memory stage only
  assign forwardAD = (rsD != '0) && (rsD == writeRegM) && regWriteM;
  assign forwardBD = (rtD != '0) && (rtD == writeRegM) && regWriteM;

  // ALU sources --------------------
  always_comb begin
    forwardAE = 2'b00;
    forwardBE = 2'b00;
    if (rsE != '0) begin
      if (rsE == writeRegM && regWriteM) forwardAE = 2'b10;      // Memory wins
      else if (rsE == writeRegW && regWriteW) forwardAE = 2'b01;
    end
    if (rtE != '0) begin
      if (rtE == writeRegM && regWriteM) forwardBE = 2'b10;
      else if (rtE == writeRegW && regWriteW) forwardBE = 2'b01;
    end
  end

  assign loadUseStall = memToRegE && (rtE != '0) && (rtE == rsD || rtE == rtD);
  assign branchStall  = branchD &&
    ((regWriteE && writeRegE != '0 && (writeRegE == rsD || writeRegE == rtD)) ||
     (memToRegM && writeRegM != '0 && (writeRegM == rsD || writeRegM == rtD)));
  assign stall = loadUseStall || branchStall;

  // Stall terms key on memToReg alone, so a load must also write a register
  always_comb begin
    assert final (!memToRegE || regWriteE);
    assert final (!memToRegM || regWriteM);
  end

endmodule

`default_nettype wire

//--- design/mipsMemories.sv
//--------------------
// Instruction ROM loaded from the hex program and a single-cycle data
// RAM. Both are word-indexed and read combinationally.
//--------------------
`timescale 1ns/1ps
`default_nettype none

module mipsMemories import mipsPkg::*; (
  input  wire logic                 clk,
  input  wire logic [DataWidth-1:0] pcF,
  input  wire logic                 memWriteM,
  input  wire logic [DataWidth-1:0] aluOutM,
  input  wire logic [DataWidth-1:0] writeDataM,
  output logic [DataWidth-1:0]      instrF,
  output logic [DataWidth-1:0]      readDataM
);

  localparam int ImemIdxWidth = $clog2(ImemWords);
  localparam int DmemIdxWidth = $clog2(DmemWords);

  logic [DataWidth-1:0] imem [ImemWords];
  logic [DataWidth-1:0] dmem [DmemWords];

  initial $readmemh(ProgramFile, imem);

  // Byte offset bits dropped
  assign instrF    = imem[pcF[ImemIdxWidth+1:2]];
  assign readDataM = dmem[aluOutM[DmemIdxWidth+1:2]];

  always_ff @(posedge clk) begin
    if (memWriteM) dmem[aluOutM[DmemIdxWidth+1:2]] <= writeDataM;
  end

endmodule

`default_nettype wire

//--- design/mipsPkg.sv
//--------------------
// Shared widths, opcode and funct encodings and the ALU operation type
// for the pipelined MIPS core. Modules pull it in by wildcard import.
//--------------------
`default_nettype none

package mipsPkg;

  localparam int DataWidth    = 32;
  localparam int RegAddrWidth = 5;
  localparam int NumRegs      = 32;
  localparam int OpcodeWidth  = 6;
  localparam int FunctWidth   = 6;
  localparam int ImmWidth     = 16;

  // Opcodes --------------------
  localparam logic [OpcodeWidth-1:0] OpRType = 6'b000000;
  localparam logic [OpcodeWidth-1:0] OpLw    = 6'b100011;
  localparam logic [OpcodeWidth-1:0] OpSw    = 6'b101011;
  localparam logic [OpcodeWidth-1:0] OpBeq   = 6'b000100;
  localparam logic [OpcodeWidth-1:0] OpAddi  = 6'b001000;
  localparam logic [OpcodeWidth-1:0] OpAddiu = 6'b001001;
  localparam logic [OpcodeWidth-1:0] OpSlti  = 6'b001010;
  localparam logic [OpcodeWidth-1:0] OpAndi  = 6'b001100;
  localparam logic [OpcodeWidth-1:0] OpOri   = 6'b001101;

  // R-type funct codes --------------------
  localparam logic [FunctWidth-1:0] FnAdd  = 6'b100000;
  localparam logic [FunctWidth-1:0] FnAddu = 6'b100001;
  localparam logic [FunctWidth-1:0] FnSub  = 6'b100010;
  localparam logic [FunctWidth-1:0] FnSubu = 6'b100011;
  localparam logic [FunctWidth-1:0] FnAnd  = 6'b100100;
  localparam logic [FunctWidth-1:0] FnOr   = 6'b100101;
  localparam logic [FunctWidth-1:0] FnXor  = 6'b100110;
  localparam logic [FunctWidth-1:0] FnNor  = 6'b100111;
  localparam logic [FunctWidth-1:0] FnSlt  = 6'b101010;
  localparam logic [FunctWidth-1:0] FnSltu = 6'b101011;

  typedef enum logic [2:0] {
    AluAnd  = 3'b000,
    AluOr   = 3'b001,
    AluAdd  = 3'b010,
    AluSltu = 3'b011,
    AluXor  = 3'b100,
    AluNor  = 3'b101,
    AluSub  = 3'b110,
    AluSlt  = 3'b111
  } aluControlT;

  localparam int ImemWords = 64;
  localparam int DmemWords = 64;
  localparam string ProgramFile = "testbench/program.hex";
  localparam logic [DataWidth-1:0] ResetPc = '0;

endpackage

`default_nettype wire

//--- design/mipsSystem.sv
//--------------------
// Top level of the five-stage MIPS core with its instruction and data
// memories. Only the memory-stage store port is visible outside.
//--------------------
`timescale 1ns/1ps
`default_nettype none

module mipsSystem import mipsPkg::*; (
  input  wire logic                 clk,
  input  wire logic                 reset,
  output logic                      memWrite,
  output logic [DataWidth-1:0]      dataAddr,
  output logic [DataWidth-1:0]      writeData
);

  logic [DataWidth-1:0]    pcF, instrF, readA, readB, srcAD, srcBD, immD;
  logic [DataWidth-1:0]    aluOutM, writeDataM, readDataM, resultW;
  logic [OpcodeWidth-1:0]  opD;
  logic [FunctWidth-1:0]   functD;
  logic [RegAddrWidth-1:0] rsD, rtD, rdD, rsE, rtE;
  logic [RegAddrWidth-1:0] writeRegE, writeRegM, writeRegW;
  logic                    stall, branchD, forwardAD, forwardBD;
  logic [1:0]              forwardAE, forwardBE;
  logic                    regWriteE, regWriteM, regWriteW;
  logic                    memToRegE, memToRegM, memToRegW, memWriteM;
  logic                    aluSrcE, regDstE;
  aluControlT              aluControlE;

  fetchDecode u_fetchDecode (.clk, .reset, .instrF, .stall, .branchD, .forwardAD,
    .forwardBD, .readA, .readB, .aluOutM, .pcF, .opD, .functD, .rsD, .rtD, .rdD,
    .srcAD, .srcBD, .immD);

  controlUnit u_controlUnit (.clk, .reset, .opD, .functD, .stall, .branchD,
    .regWriteE, .regWriteM, .regWriteW, .memToRegE, .memToRegM, .memToRegW,
    .memWriteM, .aluSrcE, .regDstE, .aluControlE);

  hazardUnit u_hazardUnit (.rsD, .rtD, .rsE, .rtE, .writeRegE, .writeRegM,
    .writeRegW, .regWriteE, .regWriteM, .regWriteW, .memToRegE, .memToRegM,
    .branchD, .forwardAD, .forwardBD, .forwardAE, .forwardBE, .stall);

  // Decode reads, writeback writes on the falling edge
  registerFile u_registerFile (.clk, .writeEnable(regWriteW), .readAddrA(rsD),
    .readAddrB(rtD), .writeAddr(writeRegW), .writeData(resultW), .readA, .readB);

  executeWriteback u_executeWriteback (.clk, .reset, .stall, .srcAD, .srcBD, .immD,
    .rsD, .rtD, .rdD, .forwardAE, .forwardBE, .aluSrcE, .regDstE, .aluControlE,
    .memToRegW, .readDataM, .rsE, .rtE, .writeRegE, .writeRegM, .writeRegW,
    .aluOutM, .writeDataM, .resultW);

  mipsMemories u_mipsMemories (.clk, .pcF, .memWriteM, .aluOutM, .writeDataM,
    .instrF, .readDataM);

  assign memWrite  = memWriteM;
  assign dataAddr  = aluOutM;
  assign writeData = writeDataM;

endmodule

`default_nettype wire

//--- design/registerFile.sv
//--------------------
// 32-entry register file. Reads are combinational, the write lands on
// the falling edge so writeback and decode share one cycle.
//--------------------
`timescale 1ns/1ps
`default_nettype none

module registerFile import mipsPkg::*; (
  input  wire logic                    clk,
  input  wire logic                    writeEnable,
  input  wire logic [RegAddrWidth-1:0] readAddrA,
  input  wire logic [RegAddrWidth-1:0] readAddrB,
  input  wire logic [RegAddrWidth-1:0] writeAddr,
  input  wire logic [DataWidth-1:0]    writeData,
  output logic [DataWidth-1:0]         readA,
  output logic [DataWidth-1:0]         readB
);

  logic [DataWidth-1:0] regs [NumRegs];

  always_ff @(negedge clk) begin
    if (writeEnable) regs[writeAddr] <= writeData;
  end

  assign readA = (readAddrA != '0) ? regs[readAddrA] : '0;  // $zero reads zero
  assign readB = (readAddrB != '0) ? regs[readAddrB] : '0;

  assert property (@(negedge clk) writeEnable |-> !$isunknown(writeAddr));

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Build and run the MIPS pipeline simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module mipsSystemTb -o simv
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench failed" sim.log; then
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi
echo "Simulation finished without a failure report"

//--- src.f
design/mipsPkg.sv
design/registerFile.sv
design/fetchDecode.sv
design/controlUnit.sv
design/hazardUnit.sv
design/executeWriteback.sv
design/mipsMemories.sv
design/mipsSystem.sv
testbench/mipsSystemTb.sv

//--- testbench/mipsSystemTb.sv
//--------------------
// Testbench for the pipelined MIPS system. Runs the hex program and
// checks every data-memory store against a table of expected stores,
// in order, until the end marker arrives.
//--------------------
`timescale 1ns/1ps
`default_nettype none

module mipsSystemTb import mipsPkg::*;;

  localparam int ClockPeriod    = 40;
  localparam int ResetCycles    = 16;
  localparam int ProgramWords   = 40;
  localparam int CyclesPerWord  = 40;
  localparam int WatchdogCycles = ResetCycles + CyclesPerWord * ProgramWords;
  localparam int TableLen       = 16;
  localparam logic [DataWidth-1:0] FirstAddr   = 32'h0000_0040;
  localparam logic [DataWidth-1:0] MarkerAddr  = 32'h0000_007C;
  localparam logic [DataWidth-1:0] MarkerValue = 32'h0000_FFFF;

  logic                 clk;
  logic                 reset;
  logic                 memWrite;
  logic [DataWidth-1:0] dataAddr;
  logic [DataWidth-1:0] writeData;

  logic [DataWidth-1:0] expAddr [TableLen];
  logic [DataWidth-1:0] expData [TableLen];
  int                   errors;
  int                   storeCount;
  logic                 markerSeen;

  mipsSystem u_mipsSystem (.clk, .reset, .memWrite, .dataAddr, .writeData);

  always #(ClockPeriod / 2) clk = ~clk;

  task automatic reportMismatch(input string name, input logic [DataWidth-1:0] got,
                                input logic [DataWidth-1:0] expected);
    $display("CHECK FAILED at %0t ns: %s = 0x%08h, expected 0x%08h",
             $time, name, got, expected);
    errors++;
  endtask

  // Expected stores --------------------
  task automatic fillExpectedStores();
    logic [DataWidth-1:0] a, b, loaded;
    int                   i;
    a        = 32'd5;
    b        = 32'd7;
    for (i = 0; i < TableLen; i++) begin
      expAddr[i] = FirstAddr + DataWidth'(4 * i);
    end
    expData[0]  = a + b;
    expData[1]  = a - b;
    expData[2]  = a & b;
    expData[3]  = a | b;
    expData[4]  = a ^ b;
    expData[5]  = ~(a | b);
    expData[6]  = 32'd0;           // slti 5 against -1
    expData[7]  = 32'd1;           // slt -1 against 5
    expData[8]  = 32'd0;           // sltu all ones against 1
    expData[9]  = 32'h0000_F0F0;   // andi zero-extends
    expData[10] = {16'h0000, 16'hFFFF};                              // ori from $zero
    expData[11] = '0;  // $zero ignores writes
    loaded      = a;
    expData[12] = loaded;
    expData[13] = loaded + 32'd1;  // Load-use sum
    expData[14] = a;               // Delay slot of the taken beq
    expData[15] = MarkerValue;
  endtask

  // Reset checks --------------------
  // Sampled mid-cycle, after the flops have settled
  always @(negedge clk) begin
    if (reset) begin
      assert (memWrite === 1'b0) else begin
        $display("Store port active during reset at %0t ns", $time);
        errors++;
      end
    end
  end

  // Store checks --------------------
  always @(posedge clk) begin
    if (!reset && memWrite) begin
      if (storeCount < TableLen) begin
        assert (dataAddr == expAddr[storeCount])
          else reportMismatch("dataAddr", dataAddr, expAddr[storeCount]);
        assert (writeData == expData[storeCount])
          else reportMismatch("writeData", writeData, expData[storeCount]);
      end else begin
        $display("Unexpected extra store at %0t ns to 0x%08h", $time, dataAddr);
        errors++;
      end
      storeCount++;
      if (dataAddr == MarkerAddr && writeData == MarkerValue) markerSeen = 1'b1;
    end
  end

  // Watchdog --------------------
  initial begin
    #(WatchdogCycles * ClockPeriod);
    $display("Program did not finish: no end marker after %0d cycles", WatchdogCycles);
    errors++;
    $display("Stores seen: %0d of %0d, errors: %0d", storeCount, TableLen, errors);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    clk        = 1'b0;
    reset      = 1'b1;
    errors     = 0;
    storeCount = 0;
    markerSeen = 1'b0;
    fillExpectedStores();
    repeat (ResetCycles) @(posedge clk);
    reset <= 1'b0;

    wait (markerSeen);
    // Marker must be the last table entry, nothing missing before it
    assert (storeCount == TableLen)
      else reportMismatch("storeCount", DataWidth'(storeCount), DataWidth'(TableLen));

    $display("Stores seen: %0d of %0d, errors: %0d", storeCount, TableLen, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/program.hex
// One hex instruction word per line, address 0 first, step 4
// Stores go to 0x40..0x7C, 0xFFFF at 0x7C ends the run
20010005  // 00 addi $1, $0, 5
20020007  // 01 addi $2, $0, 7
00221820  // 02 add  $3, $1, $2
AC030040  // 03 sw   $3, 0x40($0)
00221822  // 04 sub  $3, $1, $2
AC030044  // 05 sw   $3, 0x44($0)
00221824  // 06 and  $3, $1, $2
AC030048  // 07 sw   $3, 0x48($0)
00221825  // 08 or   $3, $1, $2
AC03004C  // 09 sw   $3, 0x4C($0)
00221826  // 0A xor  $3, $1, $2
AC030050  // 0B sw   $3, 0x50($0)
00221827  // 0C nor  $3, $1, $2
AC030054  // 0D sw   $3, 0x54($0)
2824FFFF  // 0E slti $4, $1, -1
AC040058  // 0F sw   $4, 0x58($0)
2005FFFF  // 10 addi $5, $0, -1
00A1302A  // 11 slt  $6, $5, $1
AC06005C  // 12 sw   $6, 0x5C($0)
00A6382B  // 13 sltu $7, $5, $6
AC070060  // 14 sw   $7, 0x60($0)
30A8F0F0  // 15 andi $8, $5, 0xF0F0
AC080064  // 16 sw   $8, 0x64($0)
3409FFFF  // 17 ori  $9, $0, 0xFFFF
AC090068  // 18 sw   $9, 0x68($0)
20000009  // 19 addi $0, $0, 9
AC00006C  // 1A sw   $0, 0x6C($0)
AC010070  // 1B sw   $1, 0x70($0)
8C0A0070  // 1C lw   $10, 0x70($0)
214B0001  // 1D addi $11, $10, 1
AC0B0074  // 1E sw   $11, 0x74($0)
200C0005  // 1F addi $12, $0, 5
11810002  // 20 beq  $12, $1, +2 (taken)
AC0C0078  // 21 sw   $12, 0x78($0)  delay slot
AC020040  // 22 sw   $2, 0x40($0)  skipped
10220002  // 23 beq  $1, $2, +2 (not taken)
200D0003  // 24 addi $13, $0, 3  delay slot
AC09007C  // 25 sw   $9, 0x7C($0)  end marker
1000FFFF  // 26 beq  $0, $0, -1
00000000  // 27 nop
